// File: compile.f
verilog/ThorPkg.sv
verilog/ThorFetch.sv
verilog/ThorDecoder.sv
verilog/ThorRegfile.sv
verilog/ThorDecodeStage.sv
verilog/ThorFrontEnd.sv
testbench/ThorFrontEnd_checker.sv
testbench/ThorFrontEndTb.sv

// File: run.sh
#!/bin/sh
# Build the front-end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module ThorFrontEndTb -f compile.f -Mdir obj_dir -o ThorFrontEndSim \
	&& ./obj_dir/ThorFrontEndSim > sim.log 2>&1 \
	|| echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// File: testbench/ThorFrontEndTb.sv
`timescale 1ns/100ps
`default_nettype none

module ThorFrontEndTb;
import ThorPkg::*;

localparam int programCount = 60;
localparam int memWords = 128;
localparam int resetCycles = 10;
// Reset, one write per register and a margin for the pipeline fill
localparam int setupCycles = resetCycles + regCount + 20;
localparam int cyclesPerWord = 10;

localparam Opcode opTable [0:12] = '{ADDI, ANDI, ORI, ADDIL, LDB, LDBU, LDO, STB, STO,
	JMP, JEQ, R2, NOP};

typedef struct packed {
	Instruction ir;
	Address pc;
	logic rfwr;
	logic ld;
	logic ldz;
	logic st;
	logic jmp;
	logic jxx;
	logic mul;
	logic multiCycle;
	MemSize memSz;
	RegNum rt;
	Value imm;
	Value jmpTgt;
	Value a;
	Value b;
} Expected;

logic clk;
logic reset;
logic wbCyc;
logic wbStb;
Address wbAdr;
logic wbWe;
logic [selWidth-1:0] wbSel;
Instruction wbDatI = nopInstr;
logic wbAck = 1'b0;
logic wrEn;
RegNum wrReg;
Value wrData;
logic outReady = 1'b0;
logic outValid;
Instruction outIr;
Address outPc;
logic outRfwr;
logic outLd;
logic outLdz;
logic outSt;
logic outJmp;
logic outJxx;
logic outMul;
logic outMultiCycle;
MemSize outMemSz;
RegNum outRt;
Value outImm;
Value outJmpTgt;
Value outA;
Value outB;

int seed = 32'hcab91ceb;
Instruction progMem [0:memWords-1];
int progLen = 0;
Value regCopy [0:regCount-1];
Expected expectQ [$];
int cycleCount = 0;
int timeoutLimit = 0;
// Memory model state
logic memEnable = 1'b0;
logic busy = 1'b0;
int waitLeft = 0;

ThorFrontEnd u_ThorFrontEnd (.*);

// ==============================
// Helpers
// ==============================

function automatic int randomBelow(input int n);
	return int'($unsigned($random(seed)) % n);
endfunction

function automatic Value randomValue();
	return {$random(seed), $random(seed)};
endfunction

// Words past the program read as NOP
function automatic Instruction readWord(input Address adr);
	if (adr < Address'(progLen))
		return progMem[adr[6:0]];
	return nopInstr;
endfunction

function automatic Expected refDecode(input Address pc, input Instruction ir,
	input Instruction xir);
	Expected e;
	Opcode op;
	Value base;
	op = Opcode'(ir[7:0]);
	e = '0;
	e.ir = ir;
	e.pc = pc;
	e.rt = ir[14:9];
	e.memSz = octa;
	e.a = regCopy[ir[20:15]];
	e.b = regCopy[ir[26:21]];
	base = '0;
	case (op)
	ADDI:
	begin
		e.rfwr = 1'b1;
		base = {{53{ir[31]}}, ir[31:21]};
	end
	ANDI:
	begin
		e.rfwr = 1'b1;
		base = {{53{1'b1}}, ir[31:21]};
	end
	ORI:
	begin
		e.rfwr = 1'b1;
		base = {53'd0, ir[31:21]};
	end
	ADDIL:
	begin
		e.rfwr = 1'b1;
		base = {{41{ir[43]}}, ir[43:21]};
	end
	R2:
	begin
		e.rfwr = 1'b1;
		e.mul = ir[47:42] == MUL;
		e.multiCycle = e.mul;
	end
	LDB, LDBU, LDO:
	begin
		e.rfwr = 1'b1;
		e.ld = 1'b1;
		e.ldz = op == LDBU;
		e.multiCycle = op == LDO;
		e.memSz = op == LDO ? octa : byt;
		base = {{40{ir[44]}}, ir[44:21]};
	end
	STB, STO:
	begin
		e.st = 1'b1;
		e.rt = '0;
		e.memSz = op == STB ? byt : octa;
		base = {{40{ir[44]}}, ir[44:21]};
	end
	JMP:
	begin
		e.jmp = 1'b1;
		e.rt = '0;
		e.jmpTgt = {{24{ir[47]}}, ir[47:9], 1'b0};
	end
	JEQ:
	begin
		e.jxx = 1'b1;
		e.rt = '0;
		e.jmpTgt = {{42{ir[47]}}, ir[47:27], 1'b0};
	end
	default:
		;
	endcase
	// Postfix payload takes over bits 63 to 23
	if (xir[7:0] == EXI7)
		e.imm = {{34{xir[15]}}, xir[15:9], base[22:0]};
	else if (xir[7:0] == EXI23)
		e.imm = {{18{xir[31]}}, xir[31:9], base[22:0]};
	else
		e.imm = base;
	return e;
endfunction

task automatic makeProgram();
	Instruction w;
	Opcode op;
	int n;
	for (n = 0; n < programCount; n++)
	begin
		op = opTable[4'(randomBelow(13))];
		w = Instruction'(randomValue());
		w[7:0] = op;
		// Make sure register 0 shows up as a source now and then
		if (n % 8 == 0)
			w[20:15] = '0;
		if (op == R2)
			w[47:42] = randomBelow(2) == 0 ? ADD : MUL;
		progMem[progLen[6:0]] = w;
		progLen++;
		if (op inside {ADDI, ANDI, ORI, ADDIL, LDB, LDBU, LDO, STB, STO} && randomBelow(3) == 0)
		begin
			w = Instruction'(randomValue());
			w[7:0] = randomBelow(2) == 0 ? EXI7 : EXI23;
			progMem[progLen[6:0]] = w;
			progLen++;
		end
	end
endtask

// Walk the program the way fetch pairs words
task automatic buildExpected();
	Address pc;
	Instruction ir;
	Instruction xir;
	pc = resetPc;
	while (pc < Address'(progLen))
	begin
		ir = readWord(pc);
		xir = readWord(pc + 1);
		if (xir[7:0] == EXI7 || xir[7:0] == EXI23)
		begin
			expectQ.push_back(refDecode(pc, ir, xir));
			pc = pc + 2;
		end
		else
		begin
			expectQ.push_back(refDecode(pc, ir, nopInstr));
			pc = pc + 1;
		end
	end
endtask

task automatic checkValue(input string name, input Value expected, input Value actual);
	if (actual !== expected)
	begin
		$display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		$display("test failed");
		$fatal(1, "%s does not match the reference decode", name);
	end
endtask

// ==============================
// Clock, reset and setup
// ==============================

initial
begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

initial
begin
	int i;
	reset = 1'b1;
	wrEn = 1'b0;
	wrReg = '0;
	wrData = '0;
	regCopy = '{default: '0};
	for (i = 1; i < regCount; i++)
		regCopy[RegNum'(i)] = randomValue();
	makeProgram();
	buildExpected();
	timeoutLimit = progLen * cyclesPerWord + setupCycles;
	repeat (resetCycles) @(posedge clk);
	#1;
	reset = 1'b0;
	// Registers load while fetch waits for its first ack
	for (i = 0; i < regCount; i++)
	begin
		wrEn = 1'b1;
		wrReg = RegNum'(i);
		wrData = i == 0 ? randomValue() : regCopy[RegNum'(i)];
		@(posedge clk);
		#1;
	end
	wrEn = 1'b0;
	memEnable = 1'b1;
end

// Wishbone slave with 0 to 3 wait states, plus random back-pressure
always @(posedge clk)
begin
	#1;
	outReady = randomBelow(4) != 0;
	if (wbAck)
		busy = 1'b0;
	wbAck = 1'b0;
	if (memEnable && wbStb === 1'b1)
	begin
		if (!busy)
		begin
			busy = 1'b1;
			waitLeft = randomBelow(4);
		end
		if (waitLeft == 0)
		begin
			// Read-only master with all byte lanes enabled
			checkValue("wbWe", Value'(1'b0), Value'(wbWe));
			checkValue("wbSel", Value'({selWidth{1'b1}}), Value'(wbSel));
			wbDatI = readWord(wbAdr);
			wbAck = 1'b1;
		end
		else
			waitLeft--;
	end
end

// ==============================
// Compare and timeout
// ==============================

always @(negedge clk)
begin
	Expected e;
	if (!reset && outValid && outReady && expectQ.size() > 0)
	begin
		e = expectQ.pop_front();
		checkValue("outPc", Value'(e.pc), Value'(outPc));
		checkValue("outIr", Value'(e.ir), Value'(outIr));
		checkValue("outRfwr", Value'(e.rfwr), Value'(outRfwr));
		checkValue("outLd", Value'(e.ld), Value'(outLd));
		checkValue("outLdz", Value'(e.ldz), Value'(outLdz));
		checkValue("outSt", Value'(e.st), Value'(outSt));
		checkValue("outJmp", Value'(e.jmp), Value'(outJmp));
		checkValue("outJxx", Value'(e.jxx), Value'(outJxx));
		checkValue("outMul", Value'(e.mul), Value'(outMul));
		checkValue("outMultiCycle", Value'(e.multiCycle), Value'(outMultiCycle));
		checkValue("outMemSz", Value'(e.memSz), Value'(outMemSz));
		checkValue("outRt", Value'(e.rt), Value'(outRt));
		checkValue("outImm", e.imm, outImm);
		checkValue("outJmpTgt", e.jmpTgt, outJmpTgt);
		checkValue("outA", e.a, outA);
		checkValue("outB", e.b, outB);
		if (expectQ.size() == 0)
		begin
			$display("test passed");
			$finish;
		end
	end
end

always @(posedge clk)
begin
	cycleCount++;
	if (cycleCount > timeoutLimit)
	begin
		$display("Timeout: %0d instructions still missing after %0d cycles",
			expectQ.size(), cycleCount);
		$display("test failed");
		$fatal(1, "simulation ran out of cycles");
	end
end

endmodule

`default_nettype wire

// File: testbench/ThorFrontEnd_checker.sv
`timescale 1ns/100ps
`default_nettype none

module ThorFrontEndChecker
(
	input wire clk,
	input wire reset,
	input wire wbCyc,
	input wire wbStb,
	input wire ThorPkg::Address wbAdr,
	input wire wbAck,
	input wire outReady,
	input wire outValid,
	input wire ThorPkg::Instruction outIr,
	input wire ThorPkg::Address outPc,
	input wire ThorPkg::Value outImm,
	input wire ThorPkg::Value outA,
	input wire ThorPkg::Value outB
);

// ==============================
// Wishbone master
// ==============================

stbInCyc: assert property (@(posedge clk) disable iff (reset) wbStb |-> wbCyc)
	else $error("wbStb high outside a bus cycle");

// Address holds until the slave acks
adrStable: assert property (@(posedge clk) disable iff (reset)
	(wbStb && !wbAck) |=> $stable(wbAdr))
	else $error("wbAdr changed during a pending access");

// ==============================
// Decode output
// ==============================

outHold: assert property (@(posedge clk) disable iff (reset)
	(outValid && !outReady) |=> (outValid && $stable(outIr) && $stable(outPc)
	&& $stable(outImm) && $stable(outA) && $stable(outB)))
	else $error("decode output changed under back-pressure");

quietAfterReset: assert property (@(posedge clk) reset |=> (!wbCyc && !outValid))
	else $error("bus cycle or valid output right after reset");

endmodule

bind ThorFrontEnd ThorFrontEndChecker u_ThorFrontEndChecker
(
	.clk(clk),
	.reset(reset),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbAdr(wbAdr),
	.wbAck(wbAck),
	.outReady(outReady),
	.outValid(outValid),
	.outIr(outIr),
	.outPc(outPc),
	.outImm(outImm),
	.outA(outA),
	.outB(outB)
);

`default_nettype wire

// File: verilog/ThorFrontEnd.sv
`timescale 1ns/100ps
`default_nettype none

module ThorFrontEnd
(
	input wire clk,
	input wire reset,
	output logic wbCyc,
	output logic wbStb,
	output ThorPkg::Address wbAdr,
	output logic wbWe,
	output logic [ThorPkg::selWidth-1:0] wbSel,
	input wire ThorPkg::Instruction wbDatI,
	input wire wbAck,
	input wire wrEn,
	input wire ThorPkg::RegNum wrReg,
	input wire ThorPkg::Value wrData,
	input wire outReady,
	output logic outValid,
	output ThorPkg::Instruction outIr,
	output ThorPkg::Address outPc,
	output logic outRfwr,
	output logic outLd,
	output logic outLdz,
	output logic outSt,
	output logic outJmp,
	output logic outJxx,
	output logic outMul,
	output logic outMultiCycle,
	output ThorPkg::MemSize outMemSz,
	output ThorPkg::RegNum outRt,
	output ThorPkg::Value outImm,
	output ThorPkg::Value outJmpTgt,
	output ThorPkg::Value outA,
	output ThorPkg::Value outB
);
import ThorPkg::*;

// Fetch to decode
logic irValid;
Instruction ir;
Instruction xir;
Address pc;
logic stageReady;

// Decoder outputs
RegNum Ra;
RegNum Rb;
RegNum Rt;
logic rfwr;
logic ld;
logic ldz;
logic st;
logic jmp;
logic jxx;
logic mul;
logic multiCycle;
MemSize memSz;
Value imm;
Value jmpTgt;

// Operands
Value a;
Value b;

ThorFetch u_ThorFetch (.*);

ThorDecoder u_ThorDecoder (.*);

ThorRegfile u_ThorRegfile (.*);

ThorDecodeStage u_ThorDecodeStage (.*);

endmodule

`default_nettype wire

// File: verilog/ThorDecodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module ThorDecodeStage
(
	input wire clk,
	input wire reset,
	input wire irValid,
	input wire ThorPkg::Instruction ir,
	input wire ThorPkg::Address pc,
	input wire ThorPkg::RegNum Rt,
	input wire rfwr,
	input wire ld,
	input wire ldz,
	input wire st,
	input wire jmp,
	input wire jxx,
	input wire mul,
	input wire multiCycle,
	input wire ThorPkg::MemSize memSz,
	input wire ThorPkg::Value imm,
	input wire ThorPkg::Value jmpTgt,
	input wire ThorPkg::Value a,
	input wire ThorPkg::Value b,
	output logic stageReady,
	input wire outReady,
	output logic outValid,
	output ThorPkg::Instruction outIr,
	output ThorPkg::Address outPc,
	output logic outRfwr,
	output logic outLd,
	output logic outLdz,
	output logic outSt,
	output logic outJmp,
	output logic outJxx,
	output logic outMul,
	output logic outMultiCycle,
	output ThorPkg::MemSize outMemSz,
	output ThorPkg::RegNum outRt,
	output ThorPkg::Value outImm,
	output ThorPkg::Value outJmpTgt,
	output ThorPkg::Value outA,
	output ThorPkg::Value outB
);

logic load;

// Empty, or the current entry leaves this cycle
assign stageReady = !outValid || outReady;
assign load = irValid && stageReady;

always_ff @(posedge clk)
begin
	if (reset)
		outValid <= 1'b0;
	else if (load)
		outValid <= 1'b1;
	else if (outReady)
		outValid <= 1'b0;
end

always_ff @(posedge clk)
begin
	if (load)
	begin
		outIr <= ir;
		outPc <= pc;
		outRfwr <= rfwr;
		outLd <= ld;
		outLdz <= ldz;
		outSt <= st;
		outJmp <= jmp;
		outJxx <= jxx;
		outMul <= mul;
		outMultiCycle <= multiCycle;
		outMemSz <= memSz;
		outRt <= Rt;
		outImm <= imm;
		outJmpTgt <= jmpTgt;
		outA <= a;
		outB <= b;
	end
end

endmodule

`default_nettype wire

// File: verilog/ThorRegfile.sv
`timescale 1ns/100ps
`default_nettype none

module ThorRegfile
(
	input wire clk,
	input wire reset,
	input wire ThorPkg::RegNum Ra,
	input wire ThorPkg::RegNum Rb,
	input wire wrEn,
	input wire ThorPkg::RegNum wrReg,
	input wire ThorPkg::Value wrData,
	output ThorPkg::Value a,
	output ThorPkg::Value b
);
import ThorPkg::*;

Value regs [0:regCount-1];

always_ff @(posedge clk)
begin
	if (wrEn && wrReg != '0)
		regs[wrReg] <= wrData;
end

// Register 0 is hardwired to zero
assign a = Ra == '0 ? '0 : regs[Ra];
assign b = Rb == '0 ? '0 : regs[Rb];

endmodule

`default_nettype wire

// File: verilog/ThorDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module ThorDecoder
(
	input wire ThorPkg::Instruction ir,
	input wire ThorPkg::Instruction xir,
	output ThorPkg::RegNum Ra,
	output ThorPkg::RegNum Rb,
	output ThorPkg::RegNum Rt,
	output logic rfwr,
	output logic ld,
	output logic ldz,
	output logic st,
	output logic jmp,
	output logic jxx,
	output logic mul,
	output logic multiCycle,
	output ThorPkg::MemSize memSz,
	output ThorPkg::Value imm,
	output ThorPkg::Value jmpTgt
);
import ThorPkg::*;

Opcode op;
Opcode xop;
Func func;
Value baseImm;
Value ext7;
Value ext23;

assign op = Opcode'(ir[opHi:opLo]);
assign xop = Opcode'(xir[opHi:opLo]);
assign func = Func'(ir[funcHi:funcLo]);

// ==============================
// Register numbers
// ==============================

assign Ra = ir[raHi:raLo];
assign Rb = ir[rbHi:rbLo];

always_comb
begin
	case (op)
	JMP, JEQ:
		Rt = '0;
	// Field holds the store source instead
	STB, STO:
		Rt = '0;
	default:
		Rt = ir[rtHi:rtLo];
	endcase
end

// ==============================
// Control flags
// ==============================

always_comb
begin
	rfwr = 1'b0;
	ld = 1'b0;
	ldz = 1'b0;
	st = 1'b0;
	jmp = 1'b0;
	jxx = 1'b0;
	mul = 1'b0;
	case (op)
	ADDI, ANDI, ORI, ADDIL:
		rfwr = 1'b1;
	R2:
	begin
		rfwr = func == ADD || func == MUL;
		mul = func == MUL;
	end
	LDB, LDBU, LDO:
	begin
		rfwr = 1'b1;
		ld = 1'b1;
		ldz = op == LDBU;
	end
	STB, STO:
		st = 1'b1;
	JMP:
		jmp = 1'b1;
	JEQ:
		jxx = 1'b1;
	default:
		;
	endcase
end

// Multiply and octa load need more than one execute cycle
assign multiCycle = mul || op == LDO;

always_comb
begin
	case (op)
	LDB, LDBU, STB:
		memSz = byt;
	default:
		memSz = octa;
	endcase
end

// ==============================
// Immediate
// ==============================

always_comb
begin
	case (op)
	ADDI:
		baseImm = Value'($signed(ir[immHi:immLo]));
	// Ones on the left so the mask keeps the upper bits
	ANDI:
		baseImm = {{(valueWidth - (immHi - immLo + 1)){1'b1}}, ir[immHi:immLo]};
	ORI:
		baseImm = Value'(ir[immHi:immLo]);
	ADDIL:
		baseImm = Value'($signed(ir[immlHi:immlLo]));
	LDB, LDBU, LDO, STB, STO:
		baseImm = Value'($signed(ir[dispHi:dispLo]));
	default:
		baseImm = '0;
	endcase
end

// Postfix payloads, sign extended
assign ext7 = Value'($signed(xir[exi7Hi:exi7Lo]));
assign ext23 = Value'($signed(xir[exi23Hi:exi23Lo]));

always_comb
begin
	case (xop)
	EXI7:
		imm = {ext7[valueWidth-extLow-1:0], baseImm[extLow-1:0]};
	EXI23:
		imm = {ext23[valueWidth-extLow-1:0], baseImm[extLow-1:0]};
	default:
		imm = baseImm;
	endcase
end

// Targets are in half-word units
always_comb
begin
	case (op)
	JMP:
		jmpTgt = Value'($signed({ir[jmpHi:jmpLo], 1'b0}));
	JEQ:
		jmpTgt = Value'($signed({ir[jxxHi:jxxLo], 1'b0}));
	default:
		jmpTgt = '0;
	endcase
end

endmodule

`default_nettype wire

// File: verilog/ThorFetch.sv
`timescale 1ns/100ps
`default_nettype none

module ThorFetch
(
	input wire clk,
	input wire reset,
	output logic wbCyc,
	output logic wbStb,
	output ThorPkg::Address wbAdr,
	output logic wbWe,
	output logic [ThorPkg::selWidth-1:0] wbSel,
	input wire ThorPkg::Instruction wbDatI,
	input wire wbAck,
	input wire stageReady,
	output logic irValid,
	output ThorPkg::Instruction ir,
	output ThorPkg::Instruction xir,
	output ThorPkg::Address pc
);
import ThorPkg::*;

FetchState state;
Instruction look;
logic lookValid;
logic advance;

function automatic logic isPostfix(input Instruction w);
	Opcode op;
	op = Opcode'(w[opHi:opLo]);
	return op == EXI7 || op == EXI23;
endfunction

// Read-only master, full width transfers
assign wbCyc = state == fetchIr || state == fetchLook;
assign wbStb = wbCyc;
assign wbWe = 1'b0;
assign wbSel = '1;
assign wbAdr = state == fetchLook ? pc + Address'(1) : pc;

assign irValid = state == hold;
assign advance = irValid && stageReady;

always_ff @(posedge clk)
begin
	if (reset)
	begin
		state <= idle;
		pc <= resetPc;
		lookValid <= 1'b0;
	end
	else
	begin
		case (state)
		idle:
			state <= fetchIr;
		fetchIr:
			if (wbAck)
				state <= fetchLook;
		fetchLook:
			if (wbAck)
			begin
				// A plain word is the next instruction, keep it
				lookValid <= !isPostfix(wbDatI);
				state <= hold;
			end
		hold:
			if (advance)
			begin
				pc <= pc + (isPostfix(xir) ? Address'(2) : Address'(1));
				lookValid <= 1'b0;
				state <= lookValid ? fetchLook : fetchIr;
			end
		default:
			state <= idle;
		endcase
	end
end

// Instruction words
always_ff @(posedge clk)
begin
	if (state == fetchIr && wbAck)
		ir <= wbDatI;
	if (state == fetchLook && wbAck)
	begin
		look <= wbDatI;
		xir <= isPostfix(wbDatI) ? wbDatI : nopInstr;
	end
	if (advance && lookValid)
		ir <= look;
end

endmodule

`default_nettype wire

// File: verilog/ThorPkg.sv
`default_nettype none

package ThorPkg;

// ==============================
// Widths
// ==============================

localparam int instrWidth = 48;
localparam int valueWidth = 64;
localparam int regNumWidth = 6;
localparam int addressWidth = 32;
localparam int regCount = 2 ** regNumWidth;
// One select line per byte lane of the instruction bus
localparam int selWidth = instrWidth / 8;

typedef logic [instrWidth-1:0] Instruction;
typedef logic [valueWidth-1:0] Value;
typedef logic [regNumWidth-1:0] RegNum;
typedef logic [addressWidth-1:0] Address;

// ==============================
// Encodings
// ==============================

typedef enum logic [7:0] {
	R2    = 8'h02,
	ADDI  = 8'h04,
	ANDI  = 8'h08,
	ORI   = 8'h09,
	ADDIL = 8'h14,
	JMP   = 8'h20,
	JEQ   = 8'h26,
	EXI7  = 8'h50,
	EXI23 = 8'h51,
	LDB   = 8'h80,
	LDBU  = 8'h81,
	LDO   = 8'h86,
	STB   = 8'h90,
	STO   = 8'h93,
	NOP   = 8'hF1
} Opcode;

// R2 function codes
typedef enum logic [5:0] {
	ADD = 6'h04,
	MUL = 6'h08
} Func;

typedef enum logic [1:0] {byt, wyde, tetra, octa} MemSize;

typedef enum logic [1:0] {idle, fetchIr, fetchLook, hold} FetchState;

// ==============================
// Field layout
// ==============================

localparam int opHi = 7;
localparam int opLo = 0;
localparam int funcHi = 47;
localparam int funcLo = 42;
// Stores keep their source register Rs in the Rt field
localparam int rtHi = 14;
localparam int rtLo = 9;
localparam int raHi = 20;
localparam int raLo = 15;
localparam int rbHi = 26;
localparam int rbLo = 21;
localparam int immHi = 31;
localparam int immLo = 21;
localparam int immlHi = 43;
localparam int immlLo = 21;
localparam int dispHi = 44;
localparam int dispLo = 21;
localparam int jmpHi = 47;
localparam int jmpLo = 9;
localparam int jxxHi = 47;
localparam int jxxLo = 27;
localparam int exi7Hi = 15;
localparam int exi7Lo = 9;
localparam int exi23Hi = 31;
localparam int exi23Lo = 9;
// A postfix replaces the immediate from this bit upward
localparam int extLow = 23;

localparam Instruction nopInstr = Instruction'(NOP);
localparam Address resetPc = '0;

endpackage

`default_nettype wire
